// File: all.f
hw/mipsIsaPkg.sv
hw/aluPkg.sv
hw/execCtrlIf.sv
hw/instrDecode.sv
hw/aluCore.sv
hw/branchUnit.sv
hw/execCommit.sv
hw/execStage.sv
bench/execStage_chk.sv
bench/execStageTb.sv

// File: bench/execStageTb.sv
// Directed testbench for the execute stage, the simulation top that drives and checks execStage
`timescale 1ns/1ps

module execStageTb;

    logic        clk = 1'b0;
    logic        rst;
    logic        inValid;
    logic [31:0] instr;
    logic [31:0] pc;
    logic [31:0] rs;
    logic [31:0] rt;
    logic        outValid;
    logic        regWrite;
    logic        ovfExc;
    logic        riExc;
    logic        branchTaken;
    logic [31:0] result;
    logic [31:0] branchTarget;
    logic [31:0] lfsrState = 32'hc78d040d;

    execStage dut_i (.*);

    always #5 clk = ~clk;

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb        = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], fb};
            val       = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic logic [31:0] encodeR(input logic [5:0] funct, input logic [4:0] shamt);
        mipsIsaPkg::instrWord w;
        w.rType = '{mipsIsaPkg::opSpecial, 5'd4, 5'd5, 5'd6, shamt, funct};
        return w;
    endfunction

    function automatic logic [31:0] encodeI(input logic [5:0] opcode, input logic [4:0] rtField,
                                            input logic [15:0] imm);
        mipsIsaPkg::instrWord w;
        w.iType = '{opcode, 5'd4, rtField, imm};
        return w;
    endfunction

    task automatic reportFailure(input string what);
        $display("%s", what);
        $display("SOME TESTS FAILED");
        $fatal(1, "Stopping at first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
            reportFailure($sformatf("FAILED at %0t: %s = 0x%08h, expected 0x%08h",
                                    $time, name, got, exp));
    endtask

    task automatic waitOutValid();
        int cycles;
        cycles = 0;
        while (outValid !== 1'b1) begin
            @(negedge clk);
            cycles++;
            if (cycles > 16)
                reportFailure("Timeout: outValid never rose after an instruction was sent");
        end
    endtask

    task automatic execute(input logic [31:0] word, a, b, pcVal);
        @(negedge clk);
        inValid = 1'b1;
        instr   = word;
        pc      = pcVal;
        rs      = a;
        rt      = b;
        @(negedge clk);
        inValid = 1'b0;
        waitOutValid();
    endtask

    task automatic checkFlags(input logic rw, ovf, ri, taken);
        checkValue("regWrite", 32'(regWrite), 32'(rw));
        checkValue("ovfExc", 32'(ovfExc), 32'(ovf));
        checkValue("riExc", 32'(riExc), 32'(ri));
        checkValue("branchTaken", 32'(branchTaken), 32'(taken));
    endtask

    task automatic runAlu(input logic [31:0] word, a, b, expResult, input logic expOvf);
        execute(word, a, b, 32'h0);
        checkFlags(~expOvf, expOvf, 1'b0, 1'b0);
        if (!expOvf)
            checkValue("result", result, expResult);
    endtask

    task automatic runBranch(input logic [31:0] word, a, b, pcVal, input logic [15:0] imm,
                             input logic expTaken);
        execute(word, a, b, pcVal);
        checkFlags(1'b0, 1'b0, 1'b0, expTaken);
        checkValue("branchTarget", branchTarget, pcVal + 32'd4 + {{14{imm[15]}}, imm, 2'b00});
    endtask

    task automatic testDuringReset();
        logic [31:0] words [4];
        words[0] = encodeR(mipsIsaPkg::fnXor, 5'd0);
        words[1] = encodeR(mipsIsaPkg::fnAdd, 5'd0);
        words[2] = encodeI(6'h3f, 5'd0, 16'h0000);
        words[3] = encodeI(mipsIsaPkg::opBne, 5'd0, 16'h0000);
        // Each word would raise a different flag if reset did not hold the outputs
        rs = 32'h7fffffff;
        rt = 32'd1;
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            checkValue("outValid", 32'(outValid), 32'd0);
            checkFlags(1'b0, 1'b0, 1'b0, 1'b0);
            inValid = (i < 7);
            instr   = words[i % 4];
        end
    endtask

    task automatic testResetAndStream();
        logic [31:0] a [3];
        logic [31:0] b [3];
        @(negedge clk);
        checkValue("outValid", 32'(outValid), 32'd0);
        checkFlags(1'b0, 1'b0, 1'b0, 1'b0);
        for (int i = 0; i < 3; i++) begin
            a[i] = randBits(32);
            b[i] = randBits(32);
        end
        // Three xor instructions back to back
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            if (i > 0) begin
                checkValue("outValid", 32'(outValid), 32'd1);
                checkValue("result", result, a[i-1] ^ b[i-1]);
            end
            inValid = (i < 3);
            if (i < 3) begin
                instr = encodeR(mipsIsaPkg::fnXor, 5'd0);
                rs    = a[i];
                rt    = b[i];
            end
        end
    endtask

    task automatic testRType();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] ha;
        logic [31:0] hb;
        for (int i = 0; i < 4; i++) begin
            a  = randBits(32);
            b  = randBits(32);
            // Halved operands keep the signed sum in range
            ha = $signed(a) >>> 1;
            hb = $signed(b) >>> 1;
            runAlu(encodeR(mipsIsaPkg::fnAdd, 5'd0), ha, hb, ha + hb, 1'b0);
            runAlu(encodeR(mipsIsaPkg::fnSubu, 5'd0), a, b, a - b, 1'b0);
            runAlu(encodeR(mipsIsaPkg::fnAnd, 5'd0), a, b, a & b, 1'b0);
            runAlu(encodeR(mipsIsaPkg::fnOr, 5'd0), a, b, a | b, 1'b0);
            runAlu(encodeR(mipsIsaPkg::fnXor, 5'd0), a, b, a ^ b, 1'b0);
            runAlu(encodeR(mipsIsaPkg::fnNor, 5'd0), a, b, ~(a | b), 1'b0);
            runAlu(encodeR(mipsIsaPkg::fnSlt, 5'd0), a, b, {31'b0, $signed(a) < $signed(b)}, 1'b0);
            runAlu(encodeR(mipsIsaPkg::fnSltu, 5'd0), a, b, {31'b0, a < b}, 1'b0);
        end
    endtask

    task automatic testShifts();
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  sh;
        for (int i = 0; i < 4; i++) begin
            a     = randBits(32);
            b     = randBits(32);
            b[31] = (i < 2);
            sh    = 5'(randBits(5));
            runAlu(encodeR(mipsIsaPkg::fnSll, sh), a, b, b << sh, 1'b0);
            runAlu(encodeR(mipsIsaPkg::fnSrl, sh), a, b, b >> sh, 1'b0);
            runAlu(encodeR(mipsIsaPkg::fnSra, sh), a, b, $signed(b) >>> sh, 1'b0);
            runAlu(encodeR(mipsIsaPkg::fnSllv, 5'd0), a, b, b << a[4:0], 1'b0);
            runAlu(encodeR(mipsIsaPkg::fnSrlv, 5'd0), a, b, b >> a[4:0], 1'b0);
            runAlu(encodeR(mipsIsaPkg::fnSrav, 5'd0), a, b, $signed(b) >>> a[4:0], 1'b0);
        end
    endtask

    task automatic testOverflow();
        runAlu(encodeR(mipsIsaPkg::fnAdd, 5'd0), 32'h7fffffff, 32'd1, 32'h0, 1'b1);
        runAlu(encodeR(mipsIsaPkg::fnAddu, 5'd0), 32'h7fffffff, 32'd1, 32'h80000000, 1'b0);
        runAlu(encodeR(mipsIsaPkg::fnSub, 5'd0), 32'h80000000, 32'd1, 32'h0, 1'b1);
        runAlu(encodeR(mipsIsaPkg::fnSubu, 5'd0), 32'h80000000, 32'd1, 32'h7fffffff, 1'b0);
        runAlu(encodeI(mipsIsaPkg::opAddi, 5'd0, 16'd1), 32'h7fffffff, 32'd0, 32'h0, 1'b1);
        runAlu(encodeI(mipsIsaPkg::opAddiu, 5'd0, 16'd1), 32'h7fffffff, 32'd0, 32'h80000000,
               1'b0);
        runAlu(encodeI(mipsIsaPkg::opAddi, 5'd0, 16'hffff), 32'h80000000, 32'd0, 32'h0, 1'b1);
    endtask

    task automatic testImmediate();
        logic [31:0] a;
        logic [15:0] imm;
        logic [31:0] se;
        for (int i = 0; i < 3; i++) begin
            a   = (i == 0) ? 32'd5 : randBits(32);
            imm = 16'(randBits(16)) | 16'h8000;
            se  = {{16{imm[15]}}, imm};
            runAlu(encodeI(mipsIsaPkg::opAndi, 5'd0, imm), a, 32'd0, a & {16'h0, imm}, 1'b0);
            runAlu(encodeI(mipsIsaPkg::opOri, 5'd0, imm), a, 32'd0, a | {16'h0, imm}, 1'b0);
            runAlu(encodeI(mipsIsaPkg::opXori, 5'd0, imm), a, 32'd0, a ^ {16'h0, imm}, 1'b0);
            runAlu(encodeI(mipsIsaPkg::opSlti, 5'd0, imm), a, 32'd0,
                   {31'b0, $signed(a) < $signed(se)}, 1'b0);
            runAlu(encodeI(mipsIsaPkg::opSltiu, 5'd0, imm), a, 32'd0, {31'b0, a < se}, 1'b0);
            runAlu(encodeI(mipsIsaPkg::opLui, 5'd0, imm), a, 32'd0, {imm, 16'h0}, 1'b0);
        end
    endtask

    task automatic testBranches();
        logic [31:0] pcVal;
        logic [15:0] imm;
        logic [31:0] x;
        pcVal = randBits(32) & 32'hffff_fffc;
        imm   = 16'(randBits(16));
        x     = randBits(32);
        runBranch(encodeI(mipsIsaPkg::opBeq, 5'd0, imm), x, x, pcVal, imm, 1'b1);
        runBranch(encodeI(mipsIsaPkg::opBeq, 5'd0, imm), x, x ^ 32'h1, pcVal, imm, 1'b0);
        runBranch(encodeI(mipsIsaPkg::opBne, 5'd0, imm), x, x ^ 32'h100, pcVal, imm, 1'b1);
        runBranch(encodeI(mipsIsaPkg::opBne, 5'd0, imm), x, x, pcVal, imm, 1'b0);
        runBranch(encodeI(mipsIsaPkg::opBlez, 5'd0, imm), 32'd0, x, pcVal, imm, 1'b1);
        runBranch(encodeI(mipsIsaPkg::opBlez, 5'd0, imm), 32'hfffffff0, x, pcVal, imm, 1'b1);
        runBranch(encodeI(mipsIsaPkg::opBlez, 5'd0, imm), 32'd5, x, pcVal, imm, 1'b0);
        runBranch(encodeI(mipsIsaPkg::opBgtz, 5'd0, imm), 32'd7, x, pcVal, imm, 1'b1);
        runBranch(encodeI(mipsIsaPkg::opBgtz, 5'd0, imm), 32'd0, x, pcVal, imm, 1'b0);
        // bltz and bgez select through the rt field
        runBranch(encodeI(mipsIsaPkg::opRegimm, mipsIsaPkg::rtBltz, imm), 32'hfffffffd, x,
                  pcVal, imm, 1'b1);
        runBranch(encodeI(mipsIsaPkg::opRegimm, mipsIsaPkg::rtBltz, imm), 32'd0, x,
                  pcVal, imm, 1'b0);
        runBranch(encodeI(mipsIsaPkg::opRegimm, mipsIsaPkg::rtBgez, imm), 32'd0, x,
                  pcVal, imm, 1'b1);
        runBranch(encodeI(mipsIsaPkg::opRegimm, mipsIsaPkg::rtBgez, imm), 32'hffffffff, x,
                  pcVal, imm, 1'b0);
    endtask

    task automatic testReserved();
        execute(encodeI(6'h3f, 5'd0, 16'h1234), randBits(32), randBits(32), 32'h0);
        checkFlags(1'b0, 1'b0, 1'b1, 1'b0);
        execute(encodeR(6'h3f, 5'd0), 32'h7fffffff, 32'd1, 32'h0);
        checkFlags(1'b0, 1'b0, 1'b1, 1'b0);
        execute(encodeI(mipsIsaPkg::opRegimm, 5'h1f, 16'h0010), 32'd0, 32'd0, 32'h0);
        checkFlags(1'b0, 1'b0, 1'b1, 1'b0);
    endtask

    initial begin
        rst     = 1'b1;
        inValid = 1'b0;
        instr   = '0;
        pc      = '0;
        rs      = '0;
        rt      = '0;
        testDuringReset();
        rst = 1'b0;
        testResetAndStream();
        testRType();
        testShifts();
        testOverflow();
        testImmediate();
        testBranches();
        testReserved();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: bench/execStage_chk.sv
// Assertion checker bound into the execute stage output register to watch valid and flag rules
`timescale 1ns/1ps

module execStageChk (
    input logic clk,
    input logic rst,
    input logic inValid,
    input logic outValid,
    input logic regWrite,
    input logic ovfExc,
    input logic riExc,
    input logic branchTaken
);

    validFollows: assert property (@(posedge clk) disable iff (rst) inValid |=> outValid)
        else $error("outValid did not follow inValid");

    validDrops: assert property (@(posedge clk) disable iff (rst) !inValid |=> !outValid)
        else $error("outValid high without a valid instruction");

    // An exception never writes back
    excNoWrite: assert property (@(posedge clk) disable iff (rst)
        (riExc || ovfExc) |-> !regWrite)
        else $error("regWrite set together with an exception");

    quietWhenIdle: assert property (@(posedge clk) disable iff (rst)
        !outValid |-> !(regWrite || ovfExc || riExc || branchTaken))
        else $error("Flag set while outValid is low");

endmodule

bind execCommit execStageChk chk_i (
    .clk         (clk),
    .rst         (rst),
    .inValid     (inValid),
    .outValid    (outValid),
    .regWrite    (regWrite),
    .ovfExc      (ovfExc),
    .riExc       (riExc),
    .branchTaken (branchTaken)
);

// File: hw/aluCore.sv
// Combinational integer ALU of the execute stage, producing the result and signed overflow
`timescale 1ns/1ps

module aluCore (
    execCtrlIf.alu      ctrl,
    input  aluPkg::word rs,
    input  aluPkg::word rt,
    output aluPkg::word result,
    output logic        ovfExc
);

    aluPkg::word opB;
    logic [4:0]  varAmt;
    logic [32:0] sumExt;
    logic [32:0] diffExt;
    logic        overflow;

    assign opB    = ctrl.useImm ? ctrl.immExt : rt;
    assign varAmt = rs[4:0];

    // One extra sign bit, overflow when the top two bits differ
    assign sumExt  = {rs[31], rs} + {opB[31], opB};
    assign diffExt = {rs[31], rs} - {opB[31], opB};

    // Unsigned forms never trap
    assign ovfExc = overflow & ~ctrl.aluUnsigned;

    always_comb begin
        overflow = 1'b0;
        case (ctrl.op)
            aluPkg::aluNop:  result = '0;
            aluPkg::aluAdd: begin
                result   = sumExt[31:0];
                overflow = sumExt[32] != sumExt[31];
            end
            aluPkg::aluSub: begin
                result   = diffExt[31:0];
                overflow = diffExt[32] != diffExt[31];
            end
            aluPkg::aluSll:  result = opB << ctrl.shamt;
            aluPkg::aluSllv: result = opB << varAmt;
            aluPkg::aluSrl:  result = opB >> ctrl.shamt;
            aluPkg::aluSrlv: result = opB >> varAmt;
            aluPkg::aluSra:  result = $signed(opB) >>> ctrl.shamt;
            aluPkg::aluSrav: result = $signed(opB) >>> varAmt;
            aluPkg::aluAnd:  result = rs & opB;
            aluPkg::aluOr:   result = rs | opB;
            aluPkg::aluNor:  result = ~(rs | opB);
            aluPkg::aluXor:  result = rs ^ opB;
            aluPkg::aluSlt: begin
                if (ctrl.aluUnsigned)
                    result = {31'b0, rs < opB};
                else
                    result = {31'b0, $signed(rs) < $signed(opB)};
            end
            aluPkg::aluNum2: result = opB;
            default:         result = aluPkg::fillWord;
        endcase
    end

endmodule

// File: hw/aluPkg.sv
// Execute-side encodings: ALU operation codes, branch kinds and the data word type
package aluPkg;

    localparam int wordW = 32;

    typedef logic [wordW-1:0] word;

    // Result for codes the ALU does not implement
    localparam word fillWord = 32'hDEADBEEF;

    typedef enum logic [3:0] {
        aluNop  = 4'd0,
        aluAdd  = 4'd1,
        aluSub  = 4'd2,
        aluSll  = 4'd3,
        aluSllv = 4'd4,
        aluSrl  = 4'd5,
        aluSrlv = 4'd6,
        aluSra  = 4'd7,
        aluSrav = 4'd8,
        aluAnd  = 4'd9,
        aluOr   = 4'd10,
        aluNor  = 4'd11,
        aluXor  = 4'd12,
        aluSlt  = 4'd13,
        aluNum2 = 4'd14,
        aluFill = 4'd15
    } aluOp;

    typedef enum logic [2:0] {
        brNone,
        brBeq,
        brBne,
        brBlez,
        brBgtz,
        brBltz,
        brBgez
    } branchKind;

endpackage

// File: hw/branchUnit.sv
// Conditional branch evaluation and target address for the execute stage
`timescale 1ns/1ps

module branchUnit (
    execCtrlIf.branch   ctrl,
    input  aluPkg::word rs,
    input  aluPkg::word rt,
    input  aluPkg::word pc,
    output logic        taken,
    output aluPkg::word target
);

    logic equal;
    logic rsNeg;
    logic rsZero;

    assign equal  = rs == rt;
    assign rsNeg  = rs[31];
    assign rsZero = rs == '0;

    // Immediate already sign-extended by the decoder, scale to a word offset
    assign target = pc + 32'd4 + {ctrl.immExt[29:0], 2'b00};

    always_comb begin
        case (ctrl.brKind)
            aluPkg::brBeq:  taken = equal;
            aluPkg::brBne:  taken = ~equal;
            aluPkg::brBlez: taken = rsNeg | rsZero;
            aluPkg::brBgtz: taken = ~rsNeg & ~rsZero;
            aluPkg::brBltz: taken = rsNeg;
            aluPkg::brBgez: taken = ~rsNeg;
            default:        taken = 1'b0;
        endcase
    end

endmodule

// File: hw/execCommit.sv
// Output register of the execute stage, merging ALU, branch and exception results
`timescale 1ns/1ps

module execCommit (
    input  logic        clk,
    input  logic        rst,
    input  logic        inValid,
    execCtrlIf.commit   ctrl,
    input  aluPkg::word aluResult,
    input  logic        aluOvf,
    input  logic        brTaken,
    input  aluPkg::word brTarget,
    output logic        outValid,
    output aluPkg::word result,
    output logic        regWrite,
    output logic        ovfExc,
    output logic        riExc,
    output logic        branchTaken,
    output aluPkg::word branchTarget
);

    logic ovfNow;
    logic isBranch;

    // Reserved instruction takes priority over overflow
    assign ovfNow   = aluOvf & ~ctrl.riExc;
    assign isBranch = ctrl.brKind != aluPkg::brNone;

    always_ff @(posedge clk) begin
        if (rst) begin
            outValid    <= 1'b0;
            regWrite    <= 1'b0;
            ovfExc      <= 1'b0;
            riExc       <= 1'b0;
            branchTaken <= 1'b0;
        end else begin
            outValid    <= inValid;
            regWrite    <= inValid & ctrl.regWrite & ~ovfNow;
            ovfExc      <= inValid & ovfNow;
            riExc       <= inValid & ctrl.riExc;
            branchTaken <= inValid & isBranch & brTaken;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid) begin
            result       <= aluResult;
            branchTarget <= brTarget;
        end
    end

endmodule

// File: hw/execCtrlIf.sv
// Decoded control bundle, driven by the decoder and read by the ALU, branch unit and commit
`timescale 1ns/1ps

interface execCtrlIf;

    aluPkg::aluOp                  op;
    logic [mipsIsaPkg::shamtW-1:0] shamt;
    logic                          aluUnsigned;
    logic                          useImm;
    aluPkg::word                   immExt;
    aluPkg::branchKind             brKind;
    logic                          regWrite;
    logic                          riExc;

    modport decoder (
        output op, shamt, aluUnsigned, useImm, immExt, brKind, regWrite, riExc
    );

    modport alu (
        input op, shamt, aluUnsigned, useImm, immExt
    );

    modport branch (
        input brKind, immExt
    );

    // Exception and writeback state for the output register
    modport commit (
        input regWrite, riExc, brKind
    );

endinterface

// File: hw/execStage.sv
// Top of the MIPS-I execute stage, one registered result per valid instruction
`timescale 1ns/1ps

module execStage (
    input  logic        clk,
    input  logic        rst,
    input  logic        inValid,
    input  logic [31:0] instr,
    input  logic [31:0] pc,
    input  logic [31:0] rs,
    input  logic [31:0] rt,
    output logic        outValid,
    output logic [31:0] result,
    output logic        regWrite,
    output logic        ovfExc,
    output logic        riExc,
    output logic        branchTaken,
    output logic [31:0] branchTarget
);

    aluPkg::word aluResult;
    logic        aluOvf;
    logic        brTaken;
    aluPkg::word brTarget;

    execCtrlIf ctrlBus ();

    instrDecode decode_i (
        .instr (instr),
        .ctrl  (ctrlBus.decoder)
    );

    aluCore alu_i (
        .ctrl   (ctrlBus.alu),
        .rs     (rs),
        .rt     (rt),
        .result (aluResult),
        .ovfExc (aluOvf)
    );

    branchUnit branch_i (
        .ctrl   (ctrlBus.branch),
        .rs     (rs),
        .rt     (rt),
        .pc     (pc),
        .taken  (brTaken),
        .target (brTarget)
    );

    execCommit commit_i (
        .clk          (clk),
        .rst          (rst),
        .inValid      (inValid),
        .ctrl         (ctrlBus.commit),
        .aluResult    (aluResult),
        .aluOvf       (aluOvf),
        .brTaken      (brTaken),
        .brTarget     (brTarget),
        .outValid     (outValid),
        .result       (result),
        .regWrite     (regWrite),
        .ovfExc       (ovfExc),
        .riExc        (riExc),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget)
    );

endmodule

// File: hw/instrDecode.sv
// Combinational instruction decoder, turns one MIPS-I word into the execute control bundle
`timescale 1ns/1ps

module instrDecode (
    input  mipsIsaPkg::instrWord instr,
    execCtrlIf.decoder           ctrl
);

    aluPkg::word signExt;
    aluPkg::word zeroExt;
    aluPkg::word upperImm;

    assign signExt  = {{16{instr.iType.imm[15]}}, instr.iType.imm};
    assign zeroExt  = {16'h0000, instr.iType.imm};
    assign upperImm = {instr.iType.imm, 16'h0000};

    always_comb begin
        ctrl.op          = aluPkg::aluNop;
        ctrl.shamt       = instr.rType.shamt;
        ctrl.aluUnsigned = 1'b0;
        ctrl.useImm      = 1'b0;
        ctrl.immExt      = signExt;
        ctrl.brKind      = aluPkg::brNone;
        ctrl.regWrite    = 1'b0;
        ctrl.riExc       = 1'b0;

        case (instr.iType.opcode)
            mipsIsaPkg::opSpecial: begin
                ctrl.regWrite = 1'b1;
                case (instr.rType.funct)
                    mipsIsaPkg::fnSll:  ctrl.op = aluPkg::aluSll;
                    mipsIsaPkg::fnSrl:  ctrl.op = aluPkg::aluSrl;
                    mipsIsaPkg::fnSra:  ctrl.op = aluPkg::aluSra;
                    mipsIsaPkg::fnSllv: ctrl.op = aluPkg::aluSllv;
                    mipsIsaPkg::fnSrlv: ctrl.op = aluPkg::aluSrlv;
                    mipsIsaPkg::fnSrav: ctrl.op = aluPkg::aluSrav;
                    mipsIsaPkg::fnAdd:  ctrl.op = aluPkg::aluAdd;
                    mipsIsaPkg::fnAddu: begin
                        ctrl.op          = aluPkg::aluAdd;
                        ctrl.aluUnsigned = 1'b1;
                    end
                    mipsIsaPkg::fnSub:  ctrl.op = aluPkg::aluSub;
                    mipsIsaPkg::fnSubu: begin
                        ctrl.op          = aluPkg::aluSub;
                        ctrl.aluUnsigned = 1'b1;
                    end
                    mipsIsaPkg::fnAnd:  ctrl.op = aluPkg::aluAnd;
                    mipsIsaPkg::fnOr:   ctrl.op = aluPkg::aluOr;
                    mipsIsaPkg::fnXor:  ctrl.op = aluPkg::aluXor;
                    mipsIsaPkg::fnNor:  ctrl.op = aluPkg::aluNor;
                    mipsIsaPkg::fnSlt:  ctrl.op = aluPkg::aluSlt;
                    mipsIsaPkg::fnSltu: begin
                        ctrl.op          = aluPkg::aluSlt;
                        ctrl.aluUnsigned = 1'b1;
                    end
                    default: begin
                        ctrl.regWrite = 1'b0;
                        ctrl.riExc    = 1'b1;
                    end
                endcase
            end
            // bltz and bgez share one opcode, rt picks which
            mipsIsaPkg::opRegimm: begin
                case (instr.iType.rt)
                    mipsIsaPkg::rtBltz: ctrl.brKind = aluPkg::brBltz;
                    mipsIsaPkg::rtBgez: ctrl.brKind = aluPkg::brBgez;
                    default:            ctrl.riExc  = 1'b1;
                endcase
            end
            mipsIsaPkg::opBeq:  ctrl.brKind = aluPkg::brBeq;
            mipsIsaPkg::opBne:  ctrl.brKind = aluPkg::brBne;
            mipsIsaPkg::opBlez: ctrl.brKind = aluPkg::brBlez;
            mipsIsaPkg::opBgtz: ctrl.brKind = aluPkg::brBgtz;
            mipsIsaPkg::opAddi, mipsIsaPkg::opAddiu: begin
                ctrl.op          = aluPkg::aluAdd;
                ctrl.useImm      = 1'b1;
                ctrl.regWrite    = 1'b1;
                ctrl.aluUnsigned = (instr.iType.opcode == mipsIsaPkg::opAddiu);
            end
            mipsIsaPkg::opSlti, mipsIsaPkg::opSltiu: begin
                ctrl.op          = aluPkg::aluSlt;
                ctrl.useImm      = 1'b1;
                ctrl.regWrite    = 1'b1;
                ctrl.aluUnsigned = (instr.iType.opcode == mipsIsaPkg::opSltiu);
            end
            // Logical immediates are zero-extended
            mipsIsaPkg::opAndi, mipsIsaPkg::opOri, mipsIsaPkg::opXori: begin
                ctrl.useImm   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.immExt   = zeroExt;
                if (instr.iType.opcode == mipsIsaPkg::opAndi)
                    ctrl.op = aluPkg::aluAnd;
                else if (instr.iType.opcode == mipsIsaPkg::opOri)
                    ctrl.op = aluPkg::aluOr;
                else
                    ctrl.op = aluPkg::aluXor;
            end
            mipsIsaPkg::opLui: begin
                ctrl.op       = aluPkg::aluNum2;
                ctrl.useImm   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.immExt   = upperImm;
            end
            default: ctrl.riExc = 1'b1;
        endcase
    end

endmodule

// File: hw/mipsIsaPkg.sv
// MIPS-I instruction fields, opcode and funct codes, shared by the decoder and the testbench
package mipsIsaPkg;

    localparam int opcodeW = 6;
    localparam int regW    = 5;
    localparam int shamtW  = 5;
    localparam int functW  = 6;
    localparam int immW    = 16;

    // Primary opcodes
    localparam logic [opcodeW-1:0] opSpecial = 6'h00;
    localparam logic [opcodeW-1:0] opRegimm  = 6'h01;
    localparam logic [opcodeW-1:0] opBeq     = 6'h04;
    localparam logic [opcodeW-1:0] opBne     = 6'h05;
    localparam logic [opcodeW-1:0] opBlez    = 6'h06;
    localparam logic [opcodeW-1:0] opBgtz    = 6'h07;
    localparam logic [opcodeW-1:0] opAddi    = 6'h08;
    localparam logic [opcodeW-1:0] opAddiu   = 6'h09;
    localparam logic [opcodeW-1:0] opSlti    = 6'h0a;
    localparam logic [opcodeW-1:0] opSltiu   = 6'h0b;
    localparam logic [opcodeW-1:0] opAndi    = 6'h0c;
    localparam logic [opcodeW-1:0] opOri     = 6'h0d;
    localparam logic [opcodeW-1:0] opXori    = 6'h0e;
    localparam logic [opcodeW-1:0] opLui     = 6'h0f;

    // Funct codes under opSpecial
    localparam logic [functW-1:0] fnSll  = 6'h00;
    localparam logic [functW-1:0] fnSrl  = 6'h02;
    localparam logic [functW-1:0] fnSra  = 6'h03;
    localparam logic [functW-1:0] fnSllv = 6'h04;
    localparam logic [functW-1:0] fnSrlv = 6'h06;
    localparam logic [functW-1:0] fnSrav = 6'h07;
    localparam logic [functW-1:0] fnAdd  = 6'h20;
    localparam logic [functW-1:0] fnAddu = 6'h21;
    localparam logic [functW-1:0] fnSub  = 6'h22;
    localparam logic [functW-1:0] fnSubu = 6'h23;
    localparam logic [functW-1:0] fnAnd  = 6'h24;
    localparam logic [functW-1:0] fnOr   = 6'h25;
    localparam logic [functW-1:0] fnXor  = 6'h26;
    localparam logic [functW-1:0] fnNor  = 6'h27;
    localparam logic [functW-1:0] fnSlt  = 6'h2a;
    localparam logic [functW-1:0] fnSltu = 6'h2b;

    // Branch selectors carried in rt under opRegimm
    localparam logic [regW-1:0] rtBltz = 5'h00;
    localparam logic [regW-1:0] rtBgez = 5'h01;

    typedef struct packed {
        logic [opcodeW-1:0] opcode;
        logic [regW-1:0]    rs;
        logic [regW-1:0]    rt;
        logic [regW-1:0]    rd;
        logic [shamtW-1:0]  shamt;
        logic [functW-1:0]  funct;
    } rFields;

    typedef struct packed {
        logic [opcodeW-1:0] opcode;
        logic [regW-1:0]    rs;
        logic [regW-1:0]    rt;
        logic [immW-1:0]    imm;
    } iFields;

    // Same 32 bits, read as register or immediate format
    typedef union packed {
        rFields rType;
        iFields iType;
    } instrWord;

endpackage

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert -f all.f --top-module execStageTb -o execStageSim
./obj_dir/execStageSim 2>&1 | tee sim.log
if grep -q "SOME TESTS FAILED" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
if ! grep -q "ALL TESTS PASSED" sim.log; then
    echo "Simulation ended without completing"
    exit 1
fi
echo "Simulation passed"
